// File: hw/sram_pkg.sv
package sram_pkg;

    // external chip geometry, 256K x 16
    localparam int ADDR_BITS = 18;
    localparam int DATA_BITS = 16;

    // bus turnaround spacing between accesses
    localparam int RECOVERY_WIDTH = 2;
    localparam logic [RECOVERY_WIDTH-1:0] RECOVERY_CYCLES = 2'd2; // idle cycles after ack drops

    // access direction, one bit
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // access sequencer states
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0, // waiting for req
        ST_ISSUE   = 3'd1, // issue pulse to the phy
        ST_CAPTURE = 3'd2, // strobe and mid-cycle capture in flight
        ST_ACK     = 3'd3, // ack held until req drops
        ST_RECOVER = 3'd4  // waiting on the recovery timer
    } state_e;

endpackage

// File: hw/sram_recovery_timer.sv
`timescale 1ns/1ps

module sram_recovery_timer (
    input  logic I_clk,
    input  logic arst_n,
    input  logic start,
    output logic busy
);

    logic [sram_pkg::RECOVERY_WIDTH-1:0] count;

    // reload on start, else run down and park at zero
    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (start) begin
            count <= sram_pkg::RECOVERY_CYCLES;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0); // lets the data pins turn around

endmodule

// File: hw/sram_access_fsm.sv
`timescale 1ns/1ps

module sram_access_fsm (
    input  logic I_clk,
    input  logic arst_n,
    input  logic req,
    input  logic busy,
    output logic ack,
    output logic issue,
    output logic start
);

    sram_pkg::state_e state;
    sram_pkg::state_e state_nx;

    // one access in flight, the client waits on ack
    always_comb begin
        state_nx = state;
        case (state)
            sram_pkg::ST_IDLE: begin
                if (req) begin
                    state_nx = sram_pkg::ST_ISSUE;
                end
            end
            sram_pkg::ST_ISSUE: begin
                state_nx = sram_pkg::ST_CAPTURE; // phy registers pins here
            end
            sram_pkg::ST_CAPTURE: begin
                state_nx = sram_pkg::ST_ACK;     // read data lands in rdata
            end
            sram_pkg::ST_ACK: begin
                if (!req) begin
                    state_nx = sram_pkg::ST_RECOVER;
                end
            end
            sram_pkg::ST_RECOVER: begin
                // timer loads one cycle after start, so wait on both
                if (!busy && !start) begin
                    state_nx = sram_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nx = sram_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= sram_pkg::ST_IDLE;
            ack   <= 1'b0;
            start <= 1'b0;
        end else begin
            state <= state_nx;
            ack   <= (state_nx == sram_pkg::ST_ACK);
            start <= (state == sram_pkg::ST_ACK) && !req; // same edge that drops ack
        end
    end

    assign issue = (state == sram_pkg::ST_ISSUE);

endmodule

// File: hw/sram_phy.sv
`timescale 1ns/1ps

module sram_phy (
    input  logic                             I_clk,
    input  logic                             arst_n,
    input  logic                             issue,
    input  sram_pkg::op_e                    op,
    input  logic [sram_pkg::ADDR_BITS-1:0]   addr,
    input  logic [sram_pkg::DATA_BITS-1:0]   wdata,
    input  logic                             ub,
    input  logic                             lb,
    output logic [sram_pkg::DATA_BITS-1:0]   rdata,
    output logic [sram_pkg::ADDR_BITS-1:0]   chip_addr,
    output logic                             chip_ce_n,
    output logic                             chip_oe_n,
    output logic                             chip_we_n,
    output logic                             chip_ub_n,
    output logic                             chip_lb_n,
    inout  wire  [sram_pkg::DATA_BITS-1:0]   chip_data
);

    logic                           write_tgl;    // rising-edge half of the write pair
    logic                           write_tgl_n;  // falling-edge copy
    logic                           read_tgl;
    logic                           read_tgl_n;
    logic                           write_active;
    logic                           read_active;
    logic                           capture_q;    // read issued on the last rising edge
    logic [sram_pkg::DATA_BITS-1:0] wdata_q;
    logic [sram_pkg::DATA_BITS-1:0] din_q;        // falling-edge input register

    // strobe is live from the issue edge to the next falling edge
    assign write_active = (write_tgl != write_tgl_n);
    assign read_active  = (read_tgl != read_tgl_n);

    assign chip_we_n = ~write_active;
    assign chip_oe_n = ~read_active;

    // only drive the bus while writing
    assign chip_data = write_active ? wdata_q : {sram_pkg::DATA_BITS{1'bz}};

    // toggle flops, flipping one opens a half-cycle strobe
    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            write_tgl <= 1'b0;
            read_tgl  <= 1'b0;
        end else if (issue) begin
            if (op == sram_pkg::OP_WRITE) begin
                write_tgl <= ~write_tgl_n;
            end else begin
                read_tgl <= ~read_tgl_n;
            end
        end
    end

    // copies catch up on the falling edge, which closes the strobe
    always_ff @(negedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            write_tgl_n <= 1'b0;
            read_tgl_n  <= 1'b0;
        end else begin
            write_tgl_n <= write_tgl;
            read_tgl_n  <= read_tgl;
        end
    end

    // control pin registers
    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            chip_ce_n <= 1'b1;
            chip_ub_n <= 1'b1;
            chip_lb_n <= 1'b1;
            capture_q <= 1'b0;
        end else begin
            capture_q <= issue && (op == sram_pkg::OP_READ);
            if (issue) begin
                chip_ce_n <= 1'b0; // stays selected from the first access on
                chip_ub_n <= ~ub;
                chip_lb_n <= ~lb;
            end
        end
    end

    // address and write data pins
    always_ff @(posedge I_clk) begin
        if (issue) begin
            chip_addr <= addr;
            wdata_q   <= wdata;
        end
    end

    // sample mid-strobe, once the chip output has settled
    always_ff @(negedge I_clk) begin
        if (read_active) begin
            din_q <= chip_data;
        end
    end

    always_ff @(posedge I_clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (capture_q) begin
            rdata <= din_q; // held until the next read
        end
    end

endmodule

// File: hw/sram_if_top.sv
`timescale 1ns/1ps

module sram_if_top (
    input  logic                             I_clk,
    input  logic                             arst_n,
    input  logic                             req,
    input  sram_pkg::op_e                    op,
    input  logic [sram_pkg::ADDR_BITS-1:0]   addr,
    input  logic [sram_pkg::DATA_BITS-1:0]   wdata,
    input  logic                             ub,
    input  logic                             lb,
    output logic                             ack,
    output logic [sram_pkg::DATA_BITS-1:0]   rdata,
    output logic [sram_pkg::ADDR_BITS-1:0]   chip_addr,
    inout  wire  [sram_pkg::DATA_BITS-1:0]   chip_data,
    output logic                             chip_ce_n,
    output logic                             chip_oe_n,
    output logic                             chip_we_n,
    output logic                             chip_ub_n,
    output logic                             chip_lb_n
);

    logic issue; // fsm to phy, one cycle
    logic start; // fsm to timer, one cycle
    logic busy;

    sram_access_fsm sram_access_fsm_i (
        .I_clk  (I_clk),
        .arst_n (arst_n),
        .req    (req),
        .busy   (busy),
        .ack    (ack),
        .issue  (issue),
        .start  (start)
    );

    sram_recovery_timer sram_recovery_timer_i (
        .I_clk  (I_clk),
        .arst_n (arst_n),
        .start  (start),
        .busy   (busy)
    );

    // client fields go straight in, phy latches them on issue
    sram_phy sram_phy_i (
        .I_clk     (I_clk),
        .arst_n    (arst_n),
        .issue     (issue),
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .ub        (ub),
        .lb        (lb),
        .rdata     (rdata),
        .chip_addr (chip_addr),
        .chip_ce_n (chip_ce_n),
        .chip_oe_n (chip_oe_n),
        .chip_we_n (chip_we_n),
        .chip_ub_n (chip_ub_n),
        .chip_lb_n (chip_lb_n),
        .chip_data (chip_data)
    );

endmodule

// File: test/sram_chip_model.sv
`timescale 1ns/1ps

module sram_chip_model (
    input  logic [sram_pkg::ADDR_BITS-1:0] chip_addr,
    inout  wire  [sram_pkg::DATA_BITS-1:0] chip_data,
    input  logic                           chip_ce_n,
    input  logic                           chip_oe_n,
    input  logic                           chip_we_n,
    input  logic                           chip_ub_n,
    input  logic                           chip_lb_n
);

    localparam int DEPTH        = 1 << sram_pkg::ADDR_BITS;
    localparam int WRITE_SETTLE = 5; // ns into the write pulse

    logic [sram_pkg::DATA_BITS-1:0] mem [DEPTH];
    logic [sram_pkg::DATA_BITS-1:0] read_word;
    logic                           out_en;

    // low half of the address, top two bits folded into the upper bits
    function automatic logic [sram_pkg::DATA_BITS-1:0] fill_word(
        input logic [sram_pkg::ADDR_BITS-1:0] a
    );
        return a[15:0] ^ {a[17:16], 14'h0000};
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = fill_word(i[sram_pkg::ADDR_BITS-1:0]);
        end
    end

    assign read_word = mem[chip_addr];
    assign out_en    = !chip_ce_n && !chip_oe_n && chip_we_n;

    // each byte lane drives only when enabled
    assign chip_data[15:8] = (out_en && !chip_ub_n) ? read_word[15:8] : 8'hzz;
    assign chip_data[7:0]  = (out_en && !chip_lb_n) ? read_word[7:0]  : 8'hzz;

    // latch mid-pulse once address and data have settled
    always @(negedge chip_we_n) begin
        #(WRITE_SETTLE);
        if (!chip_ce_n && !chip_we_n) begin
            if (!chip_ub_n) begin
                mem[chip_addr][15:8] = chip_data[15:8];
            end
            if (!chip_lb_n) begin
                mem[chip_addr][7:0] = chip_data[7:0];
            end
        end
    end

endmodule

// File: test/sram_if_tb.sv
`timescale 1ns/1ps

module sram_if_tb;

    localparam string DATA_FILE = "test/sram_if_testdata.txt";
    localparam int    CLK_HALF  = 50;
    localparam int    ACK_EDGES = 2; // edges from req sampled to ack
    localparam int    IDLE_GAP  = int'(sram_pkg::RECOVERY_CYCLES) + 2; // fsm idle again
    localparam int    MIN_GAP   = int'(sram_pkg::RECOVERY_CYCLES) + 3;

    logic                           I_clk;
    logic                           arst_n;
    logic                           req;
    sram_pkg::op_e                  op;
    logic [sram_pkg::ADDR_BITS-1:0] addr;
    logic [sram_pkg::DATA_BITS-1:0] wdata;
    logic                           ub;
    logic                           lb;
    logic                           ack;
    logic [sram_pkg::DATA_BITS-1:0] rdata;
    logic [sram_pkg::ADDR_BITS-1:0] chip_addr;
    wire  [sram_pkg::DATA_BITS-1:0] chip_data;
    logic                           chip_ce_n;
    logic                           chip_oe_n;
    logic                           chip_we_n;
    logic                           chip_ub_n;
    logic                           chip_lb_n;

    // stimulus table with one entry per data line
    sram_pkg::op_e                  t_op[$];
    logic [sram_pkg::ADDR_BITS-1:0] t_addr[$];
    logic [sram_pkg::DATA_BITS-1:0] t_wdata[$];
    logic                           t_ub[$];
    logic                           t_lb[$];
    logic [sram_pkg::DATA_BITS-1:0] t_exp[$];
    int                             t_hold[$];

    logic [sram_pkg::DATA_BITS-1:0] exp_rdata = '0; // last read value, zero out of reset

    int seed            = 5;
    int cycle_count     = 0;
    int cycle_limit     = 0;
    int err_count       = 0;
    int pass_count      = 0;
    int fail_count      = 0;
    int we_falls        = 0;
    int oe_falls        = 0;
    int last_fall_cycle = -1;

    sram_if_top sram_if_top_i (
        .I_clk     (I_clk),
        .arst_n    (arst_n),
        .req       (req),
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .ub        (ub),
        .lb        (lb),
        .ack       (ack),
        .rdata     (rdata),
        .chip_addr (chip_addr),
        .chip_data (chip_data),
        .chip_ce_n (chip_ce_n),
        .chip_oe_n (chip_oe_n),
        .chip_we_n (chip_we_n),
        .chip_ub_n (chip_ub_n),
        .chip_lb_n (chip_lb_n)
    );

    sram_chip_model sram_chip_model_i (
        .chip_addr (chip_addr),
        .chip_data (chip_data),
        .chip_ce_n (chip_ce_n),
        .chip_oe_n (chip_oe_n),
        .chip_we_n (chip_we_n),
        .chip_ub_n (chip_ub_n),
        .chip_lb_n (chip_lb_n)
    );

    initial begin
        I_clk = 1'b0;
        forever #CLK_HALF I_clk = ~I_clk;
    end

    always @(negedge chip_we_n) we_falls++; // one per write strobe
    always @(negedge chip_oe_n) oe_falls++;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            err_count++;
            $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %s passed at %0t ns", name, $time);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic load_testdata(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_ub;
        logic [31:0] f_lb;
        logic [31:0] f_exp;
        int          f_hold;
        ok = 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // comment and blank lines do not scan as seven fields
                if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %d", f_op, f_addr, f_wdata,
                                     f_ub, f_lb, f_exp, f_hold) == 7) begin
                    t_op.push_back(sram_pkg::op_e'(f_op[0]));
                    t_addr.push_back(f_addr[sram_pkg::ADDR_BITS-1:0]);
                    t_wdata.push_back(f_wdata[sram_pkg::DATA_BITS-1:0]);
                    t_ub.push_back(f_ub[0]);
                    t_lb.push_back(f_lb[0]);
                    t_exp.push_back(f_exp[sram_pkg::DATA_BITS-1:0]);
                    t_hold.push_back(f_hold);
                end
            end
            $fclose(fd);
            ok = (t_op.size() > 0);
        end
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (3) @(posedge I_clk);
        @(negedge I_clk);
        arst_n = 1'b1;
    endtask

    task automatic check_idle_pins();
        int errs_before;
        errs_before = err_count;
        @(negedge I_clk);
        check_value(32'(ack), 32'd0, "ack after reset");
        check_value(32'(chip_we_n), 32'd1, "chip_we_n after reset");
        check_value(32'(chip_oe_n), 32'd1, "chip_oe_n after reset");
        check_value(32'(chip_ce_n), 32'd1, "chip_ce_n before first access");
        check_value(32'(rdata), 32'd0, "rdata after reset");
        report_test("idle pins after reset", errs_before);
    endtask

    task automatic run_access(input int idx);
        int                             hold;
        int                             errs_before;
        int                             req_cycle;
        int                             ack_cycle;
        int                             drop_cycle;
        int                             we_before;
        int                             oe_before;
        bit                             spaced;
        bit                             is_write;
        string                          tag;
        errs_before = err_count;
        spaced      = (idx % 2 == 0); // odd lines go straight after the last ack
        is_write    = (t_op[idx] == sram_pkg::OP_WRITE);
        hold        = t_hold[idx];
        if (hold < 0) begin
            hold = {$random(seed)} % 8;
        end
        tag = $sformatf("%0d %s addr %05h", idx, is_write ? "write" : "read", t_addr[idx]);
        if (spaced) begin
            repeat (IDLE_GAP) @(negedge I_clk);
        end
        op        = t_op[idx];
        addr      = t_addr[idx];
        wdata     = t_wdata[idx];
        ub        = t_ub[idx];
        lb        = t_lb[idx];
        req       = 1'b1;
        req_cycle = cycle_count;
        we_before = we_falls;
        oe_before = oe_falls;
        @(negedge I_clk);
        while (!ack) @(negedge I_clk);
        ack_cycle = cycle_count;
        if (spaced) begin
            // one edge samples req and ACK_EDGES more follow
            check_value(32'(ack_cycle - req_cycle), 32'(1 + ACK_EDGES), {tag, " ack latency"});
        end else if (last_fall_cycle >= 0) begin
            check_value(32'(ack_cycle - last_fall_cycle >= MIN_GAP), 32'd1,
                        {tag, " recovery gap"});
        end
        check_value(32'(chip_ce_n), 32'd0, {tag, " chip_ce_n"});
        if (is_write) begin
            check_value(32'(rdata), 32'(exp_rdata), {tag, " rdata kept"});
        end else begin
            exp_rdata = t_exp[idx];
            check_value(32'(rdata), 32'(exp_rdata), {tag, " read data"});
        end
        repeat (hold) begin
            @(negedge I_clk);
            check_value(32'(ack), 32'd1, {tag, " ack held"});
            check_value(32'(rdata), 32'(exp_rdata), {tag, " rdata stable"});
        end
        req        = 1'b0;
        drop_cycle = cycle_count;
        @(negedge I_clk);
        while (ack) @(negedge I_clk);
        last_fall_cycle = cycle_count;
        check_value(32'(last_fall_cycle - drop_cycle), 32'd1, {tag, " ack release"});
        check_value(32'(we_falls - we_before), is_write ? 32'd1 : 32'd0, {tag, " we strobes"});
        check_value(32'(oe_falls - oe_before), is_write ? 32'd0 : 32'd1, {tag, " oe strobes"});
        report_test(tag, errs_before);
    endtask

    task automatic check_strobe_totals();
        int writes;
        int reads;
        int errs_before;
        errs_before = err_count;
        writes      = 0;
        reads       = 0;
        foreach (t_op[i]) begin
            if (t_op[i] == sram_pkg::OP_WRITE) begin
                writes++;
            end else begin
                reads++;
            end
        end
        check_value(32'(we_falls), 32'(writes), "chip_we_n falls over the run");
        check_value(32'(oe_falls), 32'(reads), "chip_oe_n falls over the run");
        report_test("strobe totals", errs_before);
    endtask

    initial begin
        bit ok;
        arst_n = 1'b0;
        req    = 1'b0;
        op     = sram_pkg::OP_READ;
        addr   = '0;
        wdata  = '0;
        ub     = 1'b0;
        lb     = 1'b0;
        load_testdata(ok);
        if (!ok) begin
            $display("could not read any access from %s, nothing was run", DATA_FILE);
            $display("Simulation failed");
        end else begin
            cycle_limit = t_op.size() * 20 + 50;
            apply_reset();
            check_idle_pins();
            for (int i = 0; i < t_op.size(); i++) begin
                run_access(i);
            end
            check_strobe_totals();
            $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
            if (fail_count == 0 && err_count == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

    // run limit armed once the table size is known
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge I_clk);
            cycle_count++;
        end
        $display("timeout after %0d clock cycles, the DUT stopped responding", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sram_if.f
hw/sram_pkg.sv
hw/sram_recovery_timer.sv
hw/sram_access_fsm.sv
hw/sram_phy.sv
hw/sram_if_top.sv
test/sram_chip_model.sv
test/sram_if_tb.sv

// File: Makefile
# Verilator flow for sram_if, run from the project root

VERILATOR ?= verilator
TOP       ?= sram_if_tb
FILELIST  ?= sram_if.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "sim PASS"; \
	else \
		echo "sim FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/sram_if_testdata.txt
// op (1 write, 0 read)  addr  wdata  ub  lb  expected rdata  hold (-1 random 0..7)
// reads use both lanes; wdata unused on reads, expected rdata unused on writes
1 00010 1234 1 1 0000 0
1 3ff00 beef 1 1 0000 2
0 00010 0000 1 1 1234 0
0 3ff00 0000 1 1 beef 3
1 12345 a5c3 1 1 0000 -1
0 12345 0000 1 1 a5c3 -1
1 00010 77ff 1 0 0000 1
0 00010 0000 1 1 7734 0
1 3ff00 1100 0 1 0000 0
0 3ff00 0000 1 1 be00 5
0 2a5a5 0000 1 1 25a5 0
0 3ffff 0000 1 1 3fff -1
1 2a5a5 ffff 1 1 0000 7
1 2a5a5 0000 0 1 0000 0
0 2a5a5 0000 1 1 ff00 2
1 00000 5a5a 1 1 0000 -1
0 00000 0000 1 1 5a5a 0
0 12345 0000 1 1 a5c3 4
1 12345 c300 1 0 0000 0
0 12345 0000 1 1 c3c3 -1
1 20000 0f0f 1 1 0000 0
0 20000 0000 1 1 0f0f 1
1 20000 f000 0 1 0000 -1
0 20000 0000 1 1 0f00 0
